// File: verilog/recovery_pkg.sv
// Shared widths and encodings for the recovery command block
`default_nettype none

package recovery_pkg;

    // Payload word and CSR width
    localparam int unsigned DATA_W = 32;

    // Command byte length width
    localparam int unsigned LEN_W = 16;

    // Receive queue geometry
    localparam int unsigned RX_DEPTH = 8;
    localparam int unsigned RX_LVL_W = 4;
    localparam int unsigned RX_PTR_W = 3;

    // Recovery command codes
    typedef enum logic [7:0] {
        CMD_PROT_CAP             = 8'd34,
        CMD_DEVICE_ID            = 8'd35,
        CMD_DEVICE_STATUS        = 8'd36,
        CMD_DEVICE_RESET         = 8'd37,
        CMD_RECOVERY_CTRL        = 8'd38,
        CMD_RECOVERY_STATUS      = 8'd39,
        CMD_HW_STATUS            = 8'd40,
        CMD_INDIRECT_CTRL        = 8'd41,
        CMD_INDIRECT_STATUS      = 8'd42,
        CMD_INDIRECT_DATA        = 8'd43,
        CMD_VENDOR               = 8'd44,
        CMD_INDIRECT_FIFO_CTRL   = 8'd45,
        CMD_INDIRECT_FIFO_STATUS = 8'd46,
        CMD_INDIRECT_FIFO_DATA   = 8'd47
    } command_e;

    // Recovery CSR indices with one index per 32-bit word
    typedef enum logic [7:0] {
        CSR_PROC_CAP_0             = 8'd0,
        CSR_PROC_CAP_1             = 8'd1,
        CSR_PROC_CAP_2             = 8'd2,
        CSR_PROC_CAP_3             = 8'd3,
        CSR_DEVICE_ID_0            = 8'd4,
        CSR_DEVICE_ID_1            = 8'd5,
        CSR_DEVICE_ID_2            = 8'd6,
        CSR_DEVICE_ID_3            = 8'd7,
        CSR_DEVICE_ID_4            = 8'd8,
        CSR_DEVICE_ID_5            = 8'd9,
        CSR_DEVICE_ID_6            = 8'd10,
        CSR_DEVICE_STATUS_0        = 8'd11,
        CSR_DEVICE_STATUS_1        = 8'd12,
        CSR_DEVICE_RESET           = 8'd13,
        CSR_RECOVERY_CTRL          = 8'd14,
        CSR_RECOVERY_STATUS        = 8'd15,
        CSR_HW_STATUS              = 8'd16,
        CSR_INDIRECT_FIFO_CTRL_0   = 8'd17,
        CSR_INDIRECT_FIFO_CTRL_1   = 8'd18,
        CSR_INDIRECT_FIFO_STATUS_0 = 8'd19,
        CSR_INDIRECT_FIFO_STATUS_1 = 8'd20,
        CSR_INDIRECT_FIFO_STATUS_2 = 8'd21,
        CSR_INDIRECT_FIFO_STATUS_3 = 8'd22,
        CSR_INDIRECT_FIFO_STATUS_4 = 8'd23,
        CSR_INDIRECT_FIFO_STATUS_5 = 8'd24
    } csr_e;

endpackage

`default_nettype wire

// File: verilog/rx_data_queue.sv
// Receive data queue that buffers payload words and serves pop requests
`timescale 1ns/1ps
`default_nettype none

module rx_data_queue (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             push_i,
    input  logic [recovery_pkg::DATA_W-1:0]  wdata_i,
    input  logic                             req_i,
    input  logic                             clr_i,
    output logic                             ack_o,
    output logic [recovery_pkg::DATA_W-1:0]  rdata_o,
    output logic                             full_o,
    output logic [recovery_pkg::RX_LVL_W-1:0] level_o
);
    import recovery_pkg::*;

    logic [DATA_W-1:0]   mem_q [RX_DEPTH];
    logic [RX_PTR_W-1:0] wptr_q;
    logic [RX_PTR_W-1:0] rptr_q;
    logic [RX_LVL_W-1:0] level_q;
    logic                pend_q;
    logic                ack_q;
    logic [DATA_W-1:0]   rdata_q;
    logic                empty;
    logic                full;
    logic                push_ok;
    logic                do_pop;

    assign empty   = (level_q == '0);
    assign full    = (level_q == RX_LVL_W'(RX_DEPTH));
    assign push_ok = push_i & ~full;

    // Serve a new or a waiting request once a word is stored
    assign do_pop = (req_i | pend_q) & ~empty & ~clr_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            level_q <= '0;
            pend_q  <= 1'b0;
            ack_q   <= 1'b0;
        end else if (clr_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            level_q <= '0;
            pend_q  <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            if (push_ok) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (do_pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            level_q <= level_q + RX_LVL_W'(push_ok) - RX_LVL_W'(do_pop);
            if (do_pop) begin
                pend_q <= 1'b0;
            end else if (req_i) begin
                pend_q <= 1'b1;
            end
            ack_q <= do_pop;
        end
    end

    // Storage and read data
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wptr_q] <= wdata_i;
        end
        if (do_pop) begin
            rdata_q <= mem_q[rptr_q];
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;
    assign full_o  = full;
    assign level_o = level_q;

    // An acknowledge always carries a word that was stored
    assert property (@(posedge clk_i) disable iff (!rst_ni) ack_o |-> $past(!empty));

endmodule

`default_nettype wire

// File: verilog/recovery_executor.sv
// Recovery command executor that maps commands to CSRs and pulls their payload words
`timescale 1ns/1ps
`default_nettype none

module recovery_executor (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          cmd_valid_i,
    input  logic                          cmd_is_rd_i,
    input  recovery_pkg::command_e        cmd_cmd_i,
    input  logic [recovery_pkg::LEN_W-1:0] cmd_len_i,
    input  logic                          cmd_error_i,
    input  logic                          rx_ack_i,
    output logic                          cmd_done_o,
    output logic                          rx_req_o,
    output logic                          rx_queue_clr_o,
    output logic                          wr_en_o,
    output recovery_pkg::csr_e            wr_sel_o
);
    import recovery_pkg::*;

    typedef enum logic [2:0] {
        Idle,
        CsrWrite,
        CsrRead,
        Error,
        Done
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic [LEN_W-1:0] dcnt_q;
    logic [LEN_W-1:0] word_cnt;
    csr_e             csr_sel_q;
    csr_e             map_csr;
    logic             map_ok;
    logic             rx_req_q;
    logic             start_write;

    // First CSR of each command and whether the code is mapped at all
    always_comb begin
        map_ok  = 1'b1;
        map_csr = CSR_PROC_CAP_0;
        case (cmd_cmd_i)
            CMD_PROT_CAP:             map_csr = CSR_PROC_CAP_0;
            CMD_DEVICE_ID:            map_csr = CSR_DEVICE_ID_0;
            CMD_DEVICE_STATUS:        map_csr = CSR_DEVICE_STATUS_0;
            CMD_DEVICE_RESET:         map_csr = CSR_DEVICE_RESET;
            CMD_RECOVERY_CTRL:        map_csr = CSR_RECOVERY_CTRL;
            CMD_RECOVERY_STATUS:      map_csr = CSR_RECOVERY_STATUS;
            CMD_HW_STATUS:            map_csr = CSR_HW_STATUS;
            CMD_INDIRECT_FIFO_CTRL:   map_csr = CSR_INDIRECT_FIFO_CTRL_0;
            CMD_INDIRECT_FIFO_STATUS: map_csr = CSR_INDIRECT_FIFO_STATUS_0;
            default:                  map_ok  = 1'b0;
        endcase
    end

    // Byte length rounded up to whole words
    assign word_cnt = (cmd_len_i >> 2) + LEN_W'(|cmd_len_i[1:0]);

    assign start_write = cmd_valid_i & ~cmd_error_i & map_ok & ~cmd_is_rd_i;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            Idle: begin
                if (cmd_valid_i) begin
                    if (cmd_error_i || !map_ok) begin
                        state_d = Error;
                    end else if (cmd_is_rd_i) begin
                        state_d = CsrRead;
                    end else begin
                        state_d = CsrWrite;
                    end
                end
            end
            CsrWrite: begin
                // Zero length has nothing to pull
                if (dcnt_q == '0) begin
                    state_d = Done;
                end else if (rx_ack_i && dcnt_q == LEN_W'(1)) begin
                    state_d = Done;
                end
            end
            CsrRead:  state_d = Done;
            Error:    state_d = Done;
            Done:     state_d = Idle;
            default:  state_d = Idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q   <= Idle;
            dcnt_q    <= '0;
            csr_sel_q <= CSR_PROC_CAP_0;
            rx_req_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            case (state_q)
                Idle: begin
                    if (cmd_valid_i) begin
                        dcnt_q    <= word_cnt;
                        csr_sel_q <= map_csr;
                    end
                    rx_req_q <= start_write & (cmd_len_i != '0);
                end
                CsrWrite: begin
                    // Index keeps moving so long writes spill into the next CSRs
                    if (rx_ack_i) begin
                        dcnt_q    <= dcnt_q - LEN_W'(1);
                        csr_sel_q <= csr_e'(csr_sel_q + 8'd1);
                    end
                    rx_req_q <= rx_ack_i & (dcnt_q != LEN_W'(1));
                end
                default: begin
                    rx_req_q <= 1'b0;
                end
            endcase
        end
    end

    assign rx_req_o       = rx_req_q;
    assign rx_queue_clr_o = (state_q == Error);
    assign cmd_done_o     = (state_q == Done);

    // Write bus to the CSR bank
    assign wr_en_o  = (state_q == CsrWrite) & rx_ack_i;
    assign wr_sel_o = csr_sel_q;

    // Done is a single-cycle pulse
    assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_done_o |=> !cmd_done_o);

    // Only one word in flight between executor and queue
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(rx_req_o && rx_ack_i));

endmodule

`default_nettype wire

// File: verilog/recovery_csr.sv
// Recovery CSR bank with the four writable registers and a read port
`timescale 1ns/1ps
`default_nettype none

module recovery_csr (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            wr_en_i,
    input  recovery_pkg::csr_e              wr_sel_i,
    input  logic [recovery_pkg::DATA_W-1:0] wr_data_i,
    input  recovery_pkg::csr_e              rd_sel_i,
    output logic [recovery_pkg::DATA_W-1:0] rd_data_o
);
    import recovery_pkg::*;

    logic [DATA_W-1:0] device_reset_q;
    logic [DATA_W-1:0] recovery_ctrl_q;
    logic [DATA_W-1:0] fifo_ctrl_0_q;
    logic [DATA_W-1:0] fifo_ctrl_1_q;
    logic              we_device_reset;
    logic              we_recovery_ctrl;
    logic              we_fifo_ctrl_0;
    logic              we_fifo_ctrl_1;

    // Write decode that lets other indices take the word with no effect
    always_comb begin
        we_device_reset  = 1'b0;
        we_recovery_ctrl = 1'b0;
        we_fifo_ctrl_0   = 1'b0;
        we_fifo_ctrl_1   = 1'b0;
        if (wr_en_i) begin
            case (wr_sel_i)
                CSR_DEVICE_RESET:         we_device_reset  = 1'b1;
                CSR_RECOVERY_CTRL:        we_recovery_ctrl = 1'b1;
                CSR_INDIRECT_FIFO_CTRL_0: we_fifo_ctrl_0   = 1'b1;
                CSR_INDIRECT_FIFO_CTRL_1: we_fifo_ctrl_1   = 1'b1;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            device_reset_q  <= '0;
            recovery_ctrl_q <= '0;
            fifo_ctrl_0_q   <= '0;
            fifo_ctrl_1_q   <= '0;
        end else begin
            if (we_device_reset) begin
                device_reset_q <= wr_data_i;
            end
            if (we_recovery_ctrl) begin
                recovery_ctrl_q <= wr_data_i;
            end
            if (we_fifo_ctrl_0) begin
                fifo_ctrl_0_q <= wr_data_i;
            end
            if (we_fifo_ctrl_1) begin
                fifo_ctrl_1_q <= wr_data_i;
            end
        end
    end

    // Read port where status and capability words read as zero
    always_comb begin
        case (rd_sel_i)
            CSR_DEVICE_RESET:         rd_data_o = device_reset_q;
            CSR_RECOVERY_CTRL:        rd_data_o = recovery_ctrl_q;
            CSR_INDIRECT_FIFO_CTRL_0: rd_data_o = fifo_ctrl_0_q;
            CSR_INDIRECT_FIFO_CTRL_1: rd_data_o = fifo_ctrl_1_q;
            default:                  rd_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/recovery_top.sv
// Recovery command block top that joins the receive queue, executor and CSR bank
`timescale 1ns/1ps
`default_nettype none

module recovery_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Decoded command
    input  logic                              cmd_valid_i,
    input  logic                              cmd_is_rd_i,
    input  recovery_pkg::command_e            cmd_cmd_i,
    input  logic [recovery_pkg::LEN_W-1:0]    cmd_len_i,
    input  logic                              cmd_error_i,
    output logic                              cmd_done_o,
    // Payload push side
    input  logic                              rx_push_i,
    input  logic [recovery_pkg::DATA_W-1:0]   rx_wdata_i,
    output logic                              rx_full_o,
    output logic [recovery_pkg::RX_LVL_W-1:0] rx_level_o,
    // CSR read port
    input  recovery_pkg::csr_e                csr_rd_sel_i,
    output logic [recovery_pkg::DATA_W-1:0]   csr_rd_data_o
);
    import recovery_pkg::*;

    logic              rx_req;
    logic              rx_ack;
    logic [DATA_W-1:0] rx_data;
    logic              rx_queue_clr;
    logic              wr_en;
    csr_e              wr_sel;

    rx_data_queue u_rx_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (rx_push_i),
        .wdata_i (rx_wdata_i),
        .req_i   (rx_req),
        .clr_i   (rx_queue_clr),
        .ack_o   (rx_ack),
        .rdata_o (rx_data),
        .full_o  (rx_full_o),
        .level_o (rx_level_o)
    );

    recovery_executor u_executor (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_is_rd_i    (cmd_is_rd_i),
        .cmd_cmd_i      (cmd_cmd_i),
        .cmd_len_i      (cmd_len_i),
        .cmd_error_i    (cmd_error_i),
        .rx_ack_i       (rx_ack),
        .cmd_done_o     (cmd_done_o),
        .rx_req_o       (rx_req),
        .rx_queue_clr_o (rx_queue_clr),
        .wr_en_o        (wr_en),
        .wr_sel_o       (wr_sel)
    );

    // Queue data goes straight to the bank while the executor picks the target
    recovery_csr u_csr (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .wr_en_i   (wr_en),
        .wr_sel_i  (wr_sel),
        .wr_data_i (rx_data),
        .rd_sel_i  (csr_rd_sel_i),
        .rd_data_o (csr_rd_data_o)
    );

endmodule

`default_nettype wire

// File: testbench/recovery_tb.sv
// Testbench for the recovery command block with a register and queue reference model
`timescale 1ns/1ps
`default_nettype none

module recovery_tb;
    import recovery_pkg::*;

    localparam int N_RANDOM        = 80;
    localparam int N_CMDS          = N_RANDOM + 7;
    localparam int WATCHDOG_CYCLES = N_CMDS * 200;

    logic                clk_i;
    logic                rst_ni;
    logic                cmd_valid_i;
    logic                cmd_is_rd_i;
    command_e            cmd_cmd_i;
    logic [LEN_W-1:0]    cmd_len_i;
    logic                cmd_error_i;
    logic                cmd_done_o;
    logic                rx_push_i;
    logic [DATA_W-1:0]   rx_wdata_i;
    logic                rx_full_o;
    logic [RX_LVL_W-1:0] rx_level_o;
    csr_e                csr_rd_sel_i;
    logic [DATA_W-1:0]   csr_rd_data_o;

    // Reference register image and queue contents
    logic [DATA_W-1:0] model_csr [32];
    logic [DATA_W-1:0] model_fifo [$];
    int                seed;
    int                value_errors;
    int                other_errors;

    recovery_top DUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_is_rd_i   (cmd_is_rd_i),
        .cmd_cmd_i     (cmd_cmd_i),
        .cmd_len_i     (cmd_len_i),
        .cmd_error_i   (cmd_error_i),
        .cmd_done_o    (cmd_done_o),
        .rx_push_i     (rx_push_i),
        .rx_wdata_i    (rx_wdata_i),
        .rx_full_o     (rx_full_o),
        .rx_level_o    (rx_level_o),
        .csr_rd_sel_i  (csr_rd_sel_i),
        .csr_rd_data_o (csr_rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // First CSR index of a command or -1 when it has no mapping
    function automatic int first_csr(input command_e code);
        case (code)
            CMD_PROT_CAP:             return 0;
            CMD_DEVICE_ID:            return 4;
            CMD_DEVICE_STATUS:        return 11;
            CMD_DEVICE_RESET:         return 13;
            CMD_RECOVERY_CTRL:        return 14;
            CMD_RECOVERY_STATUS:      return 15;
            CMD_HW_STATUS:            return 16;
            CMD_INDIRECT_FIFO_CTRL:   return 17;
            CMD_INDIRECT_FIFO_STATUS: return 19;
            default:                  return -1;
        endcase
    endfunction

    function automatic int word_count(input logic [LEN_W-1:0] len);
        return (int'(len) + 3) / 4;
    endfunction

    // Each word goes to the next index and unwritable ones drop it
    function automatic void apply_write(input int first, input int words);
        int idx;
        for (int i = 0; i < words; i++) begin
            idx = first + i;
            if (idx == 13 || idx == 14 || idx == 17 || idx == 18) begin
                model_csr[idx] = model_fifo[0];
            end
            model_fifo.pop_front();
        end
    endfunction

    task automatic check_csr(input csr_e idx, input logic [DATA_W-1:0] exp);
        csr_rd_sel_i = idx;
        #0.5;
        if (csr_rd_data_o !== exp) begin
            value_errors++;
            $display("Fail at %0t: csr_rd_data_o[%s] expected %h actual %h",
                     $time, idx.name(), exp, csr_rd_data_o);
        end
    endtask

    task automatic check_level(input logic [RX_LVL_W-1:0] exp);
        if (rx_level_o !== exp) begin
            value_errors++;
            $display("Fail at %0t: rx_level_o expected %0d actual %0d", $time, exp, rx_level_o);
        end
    endtask

    task automatic check_full(input logic exp);
        if (rx_full_o !== exp) begin
            value_errors++;
            $display("Fail at %0t: rx_full_o expected %0b actual %0b", $time, exp, rx_full_o);
        end
    endtask

    // Done must show up between min and max cycles after the command
    task automatic check_done(input int min_cycles, input int max_cycles);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < max_cycles) begin
            @(negedge clk_i);
            cycles++;
            seen = cmd_done_o;
        end
        if (!seen) begin
            other_errors++;
            $display("No done pulse within %0d cycles, at time %0t", max_cycles, $time);
        end else if (cycles < min_cycles) begin
            value_errors++;
            $display("Fail at %0t: cmd_done_o cycle expected %0d actual %0d",
                     $time, min_cycles, cycles);
        end
    endtask

    task automatic push_model(input logic [DATA_W-1:0] data);
        if (model_fifo.size() < RX_DEPTH) begin
            model_fifo.push_back(data);
        end
    endtask

    task automatic push_dut(input logic [DATA_W-1:0] data);
        rx_push_i  = 1'b1;
        rx_wdata_i = data;
        @(posedge clk_i);
        #1;
        rx_push_i  = 1'b0;
    endtask

    task automatic push_word(input logic [DATA_W-1:0] data);
        push_model(data);
        push_dut(data);
    endtask

    // Late words arrive while the executor already waits on the queue
    task automatic run_cmd(input command_e code, input logic is_rd,
                           input logic [LEN_W-1:0] len, input logic err,
                           input int late_words);
        int                first;
        int                words;
        logic              quick;
        logic [DATA_W-1:0] late_data [$];
        first = first_csr(code);
        words = word_count(len);
        quick = err || (first < 0) || is_rd || (words == 0);
        for (int i = 0; i < late_words; i++) begin
            late_data.push_back($random(seed));
            push_model(late_data[i]);
        end
        if (err || first < 0) begin
            model_fifo.delete();
        end else if (!is_rd) begin
            apply_write(first, words);
        end
        cmd_cmd_i   = code;
        cmd_is_rd_i = is_rd;
        cmd_len_i   = len;
        cmd_error_i = err;
        cmd_valid_i = 1'b1;
        @(posedge clk_i);
        #1;
        cmd_valid_i = 1'b0;
        if (late_words > 0) begin
            repeat (3) @(posedge clk_i);
            #1;
            foreach (late_data[i]) push_dut(late_data[i]);
        end
        if (quick) begin
            check_done(2, 2);
        end else begin
            check_done(2, 2 * words + 6);
        end
        check_level(RX_LVL_W'(model_fifo.size()));
        check_full(model_fifo.size() == RX_DEPTH);
        @(posedge clk_i);
        #1;
    endtask

    // Register compare after every completed command
    initial begin : compare_proc
        csr_rd_sel_i = CSR_PROC_CAP_0;
        forever begin
            @(posedge clk_i);
            #1;
            if (rst_ni && cmd_done_o) begin
                check_csr(CSR_DEVICE_RESET, model_csr[13]);
                check_csr(CSR_RECOVERY_CTRL, model_csr[14]);
                check_csr(CSR_INDIRECT_FIFO_CTRL_0, model_csr[17]);
                check_csr(CSR_INDIRECT_FIFO_CTRL_1, model_csr[18]);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        int level;
        int wc;
        int need;
        int room;
        command_e code;
        logic [LEN_W-1:0] len;
        seed         = 71865;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) begin
            model_csr[i] = '0;
        end
        rst_ni      = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_is_rd_i = 1'b0;
        cmd_cmd_i   = CMD_PROT_CAP;
        cmd_len_i   = '0;
        cmd_error_i = 1'b0;
        rx_push_i   = 1'b0;
        rx_wdata_i  = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_level('0);

        // Single word into RECOVERY_CTRL
        push_word(32'hCAFE_0001);
        run_cmd(CMD_RECOVERY_CTRL, 1'b0, 16'd4, 1'b0, 0);

        // 6 bytes round up to two words and the second one comes late
        push_word(32'h1111_2222);
        run_cmd(CMD_INDIRECT_FIFO_CTRL, 1'b0, 16'd6, 1'b0, 1);

        // Spill from DEVICE_RESET into RECOVERY_CTRL and a status word
        push_word(32'hA5A5_0001);
        push_word(32'hA5A5_0002);
        push_word(32'hA5A5_0003);
        run_cmd(CMD_DEVICE_RESET, 1'b0, 16'd12, 1'b0, 0);

        // Error flag and an unmapped code both flush the queue
        repeat (3) push_word($random(seed));
        run_cmd(CMD_RECOVERY_CTRL, 1'b0, 16'd4, 1'b1, 0);
        repeat (2) push_word($random(seed));
        run_cmd(CMD_VENDOR, 1'b0, 16'd8, 1'b0, 0);

        // Read and zero-length write leave a full queue alone
        // The last push meets a full queue and is dropped
        repeat (RX_DEPTH + 1) push_word($random(seed));
        run_cmd(CMD_RECOVERY_CTRL, 1'b1, 16'd4, 1'b0, 0);
        run_cmd(CMD_DEVICE_RESET, 1'b0, 16'd0, 1'b0, 0);

        // Random commands with enough words queued for every write
        for (int n = 0; n < N_RANDOM; n++) begin
            code  = command_e'(8'd34 + 8'(rand_below(14)));
            len   = LEN_W'(rand_below(33));
            wc    = word_count(len);
            level = model_fifo.size();
            need  = (wc > level) ? wc - level : 0;
            room  = RX_DEPTH - ((wc > level) ? wc : level);
            repeat (need + rand_below(room + 1)) push_word($random(seed));
            run_cmd(code, rand_below(5) == 0, len, rand_below(8) == 0, 0);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/recovery_pkg.sv
verilog/rx_data_queue.sv
verilog/recovery_executor.sv
verilog/recovery_csr.sv
verilog/recovery_top.sv
testbench/recovery_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the recovery block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=recovery_tb
BUILD_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f flist.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$("./$BUILD_DIR/V$TOP")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
